/* cic_audio.f */
+incdir+design
+incdir+dv
design/cic_pkg.sv
design/sine_quarter_rom.sv
design/sample_source.sv
design/decim_timer.sv
design/cic_integrator.sv
design/cic_comb.sv
design/cic_audio_top.sv
dv/cic_audio_tb.sv

/* design/cic_audio_top.sv */
////////////////////////////////////////////////////////////
// CIC audio decimator top level
// Tone or ADC source, output-rate timer
// Order-4 left and order-2 right decimators
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cic_settings.svh"

module cic_audio_top
   import cic_pkg::*;
(
   input  logic                     lr_clk,
   input  logic                     reset,
   input  src_sel_e                 src_sel,
   input  logic [`CIC_SHIFT_W-1:0]  tone_shift,
   input  sample_t                  adc_sample,
   output sample_t                  src_sample,     // Filter input, also observable
   output sample_t                  left_sample,    // Order 4
   output sample_t                  right_sample,   // Order 2
   output logic                     sample_valid
);

   localparam int LEFT_ORDER  = 4;
   localparam int RIGHT_ORDER = 2;
   localparam int LEFT_W      = `CIC_SAMPLE_W + LEFT_ORDER * `CIC_DECIM_LOG2;
   localparam int RIGHT_W     = `CIC_SAMPLE_W + RIGHT_ORDER * `CIC_DECIM_LOG2;

   logic                       sample_tick;
   logic signed [LEFT_W-1:0]   left_integ;
   logic signed [RIGHT_W-1:0]  right_integ;

   /////////////////////////////////////////////////////////
   // Source and timing
   /////////////////////////////////////////////////////////
   sample_source sample_source_i
   (
      .lr_clk     (lr_clk),
      .reset      (reset),
      .src_sel    (src_sel),
      .tone_shift (tone_shift),
      .adc_sample (adc_sample),
      .src_sample (src_sample)
   );

   decim_timer decim_timer_i
   (
      .lr_clk      (lr_clk),
      .reset       (reset),
      .sample_tick (sample_tick)
   );

   /////////////////////////////////////////////////////////
   // Left channel
   /////////////////////////////////////////////////////////
   cic_integrator #(.ORDER(LEFT_ORDER)) left_integ_i
   (
      .lr_clk    (lr_clk),
      .reset     (reset),
      .sample_in (src_sample),
      .integ_out (left_integ)
   );

   cic_comb #(.ORDER(LEFT_ORDER)) left_comb_i
   (
      .lr_clk      (lr_clk),
      .reset       (reset),
      .sample_tick (sample_tick),
      .integ_in    (left_integ),
      .sample_out  (left_sample),
      .out_valid   (sample_valid)   // Shared strobe for both channels
   );

   /////////////////////////////////////////////////////////
   // Right channel
   /////////////////////////////////////////////////////////
   cic_integrator #(.ORDER(RIGHT_ORDER)) right_integ_i
   (
      .lr_clk    (lr_clk),
      .reset     (reset),
      .sample_in (src_sample),
      .integ_out (right_integ)
   );

   cic_comb #(.ORDER(RIGHT_ORDER)) right_comb_i
   (
      .lr_clk      (lr_clk),
      .reset       (reset),
      .sample_tick (sample_tick),
      .integ_in    (right_integ),
      .sample_out  (right_sample),
      .out_valid   ()               // Same timing as the left strobe
   );

endmodule

/* design/cic_comb.sv */
////////////////////////////////////////////////////////////
// CIC comb section
// Captures the integrator on each tick
// ORDER difference stages with tick-rate delays
// DC gain removal by arithmetic shift, output and valid
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cic_settings.svh"

module cic_comb
   import cic_pkg::*;
#(
   parameter int ORDER = 4
)
(
   input  logic                                                    lr_clk,
   input  logic                                                    reset,
   input  logic                                                    sample_tick,
   input  logic signed [`CIC_SAMPLE_W+ORDER*`CIC_DECIM_LOG2-1:0]   integ_in,
   output sample_t                                                 sample_out,
   output logic                                                    out_valid
);

   localparam int GAIN_SH = ORDER * `CIC_DECIM_LOG2;   // log2 of R**ORDER
   localparam int ACC_W   = `CIC_SAMPLE_W + GAIN_SH;

   logic signed [ACC_W-1:0] cap;             // Integrator at the last tick
   logic signed [ACC_W-1:0] dly  [ORDER];    // Stage inputs, one tick old
   logic signed [ACC_W-1:0] diff [ORDER];
   logic signed [ACC_W-1:0] scaled;

   /////////////////////////////////////////////////////////
   // Difference chain
   /////////////////////////////////////////////////////////
   always_comb
   begin
      diff[0] = cap - dly[0];
      for (int k = 1; k < ORDER; k++)
         diff[k] = diff[k-1] - dly[k];
   end

   // Exact DC normalisation, gain is a power of two
   assign scaled = diff[ORDER-1] >>> GAIN_SH;

   /////////////////////////////////////////////////////////
   // Tick-rate registers
   /////////////////////////////////////////////////////////
   always_ff @(posedge lr_clk)
   begin
      if (reset)
      begin
         cap        <= '0;
         sample_out <= '0;
         out_valid  <= 1'b0;
         for (int k = 0; k < ORDER; k++)
            dly[k] <= '0;
      end
      else
      begin
         out_valid <= sample_tick;   // Single pulse per window
         if (sample_tick)
         begin
            cap        <= integ_in;
            dly[0]     <= cap;
            for (int k = 1; k < ORDER; k++)
               dly[k] <= diff[k-1];
            sample_out <= sample_t'(scaled[`CIC_SAMPLE_W-1:0]);
         end
      end
   end

endmodule

/* design/cic_integrator.sv */
////////////////////////////////////////////////////////////
// CIC integrator section
// ORDER cascaded accumulators at the input rate
// Two's complement wrap, undone by the combs
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cic_settings.svh"

module cic_integrator
   import cic_pkg::*;
#(
   parameter int ORDER = 4
)
(
   input  logic                                                    lr_clk,
   input  logic                                                    reset,
   input  sample_t                                                 sample_in,
   output logic signed [`CIC_SAMPLE_W+ORDER*`CIC_DECIM_LOG2-1:0]   integ_out
);

   // Bit growth is ORDER * log2(ratio)
   localparam int ACC_W = `CIC_SAMPLE_W + ORDER * `CIC_DECIM_LOG2;

   logic signed [ACC_W-1:0] acc [ORDER];
   logic signed [ACC_W-1:0] sample_ext;

   assign sample_ext = ACC_W'(sample_in);   // Sign extended

   /////////////////////////////////////////////////////////
   // Accumulator chain, one register per stage
   /////////////////////////////////////////////////////////
   always_ff @(posedge lr_clk)
   begin
      if (reset)
      begin
         for (int k = 0; k < ORDER; k++)
            acc[k] <= '0;
      end
      else
      begin
         acc[0] <= acc[0] + sample_ext;
         for (int k = 1; k < ORDER; k++)
            acc[k] <= acc[k] + acc[k-1];   // Feeds from the previous stage
      end
   end

   assign integ_out = acc[ORDER-1];

endmodule

/* design/cic_pkg.sv */
////////////////////////////////////////////////////////////
// Types shared by the CIC audio design
// Sample and phase words
// Source select encoding
////////////////////////////////////////////////////////////
`include "cic_settings.svh"

package cic_pkg;

   /////////////////////////////////////////////////////////
   // Data words
   /////////////////////////////////////////////////////////

   // One audio sample, signed
   typedef logic signed [`CIC_SAMPLE_W-1:0] sample_t;

   // Tone phase, wraps freely
   typedef logic [`CIC_PHASE_W-1:0] phase_t;

   /////////////////////////////////////////////////////////
   // Control encodings
   /////////////////////////////////////////////////////////

   // Filter input source
   typedef enum logic
   {
      SRC_TONE = 1'b0,   // Internal sine generator
      SRC_ADC  = 1'b1    // External converter sample
   } src_sel_e;

endpackage

/* design/cic_settings.svh */
////////////////////////////////////////////////////////////
// Shared constants for the CIC audio decimator
// Sample, phase and lookup widths
// Decimation ratio and its log2
// Tone generator base step and sine amplitude
////////////////////////////////////////////////////////////
`ifndef CIC_SETTINGS_SVH
`define CIC_SETTINGS_SVH

// Datapath widths
`define CIC_SAMPLE_W     16   // Audio sample, two's complement
`define CIC_PHASE_W      32   // Tone phase accumulator
`define CIC_ROM_ADDR_W   8    // Full-wave sine index

// Decimation
`define CIC_DECIM_RATIO  64
`define CIC_DECIM_LOG2   6    // Must match the ratio above

// Tone generator
`define CIC_TONE_STEP    32'h42f3   // Base step, roughly 200 Hz at 50 MHz
`define CIC_SHIFT_W      5          // Width of the step shift control
`define CIC_SINE_PEAK    16383      // Table amplitude at quarter wave

`endif

/* design/decim_timer.sv */
////////////////////////////////////////////////////////////
// Output-rate timer
// One-cycle tick every CIC_DECIM_RATIO clocks
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cic_settings.svh"

module decim_timer
   import cic_pkg::*;
(
   input  logic  lr_clk,
   input  logic  reset,
   output logic  sample_tick   // Comb update strobe
);

   localparam int CNT_W = `CIC_DECIM_LOG2;

   logic [CNT_W-1:0] count;

   // Last count of the window
   assign sample_tick = (count == CNT_W'(`CIC_DECIM_RATIO - 1));

   always_ff @(posedge lr_clk)
   begin
      if (reset)
         count <= '0;
      else if (sample_tick)
         count <= '0;            // Start the next window
      else
         count <= count + 1'b1;
   end

endmodule

/* design/sample_source.sv */
////////////////////////////////////////////////////////////
// Filter input source
// Tone phase accumulator with shifted step
// Sine lookup and registered source select
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cic_settings.svh"

module sample_source
   import cic_pkg::*;
(
   input  logic                     lr_clk,
   input  logic                     reset,
   input  src_sel_e                 src_sel,
   input  logic [`CIC_SHIFT_W-1:0]  tone_shift,   // Octave select for the tone
   input  sample_t                  adc_sample,
   output sample_t                  src_sample
);

   phase_t   phase;
   phase_t   phase_inc;
   sample_t  tone_sample;

   /////////////////////////////////////////////////////////
   // Phase accumulator
   /////////////////////////////////////////////////////////

   // Each shift step doubles the tone frequency
   assign phase_inc = phase_t'(`CIC_TONE_STEP) << tone_shift;

   always_ff @(posedge lr_clk)
   begin
      if (reset)
         phase <= '0;
      else
         phase <= phase + phase_inc;   // Wraps once per tone period
   end

   // Lookup on the top phase bits, one cycle of latency
   sine_quarter_rom sine_rom_i
   (
      .lr_clk    (lr_clk),
      .reset     (reset),
      .phase_idx (phase[`CIC_PHASE_W-1 -: `CIC_ROM_ADDR_W]),
      .sine      (tone_sample)
   );

   /////////////////////////////////////////////////////////
   // Source select
   /////////////////////////////////////////////////////////
   always_ff @(posedge lr_clk)
   begin
      if (reset)
         src_sample <= '0;
      else if (src_sel == SRC_ADC)
         src_sample <= adc_sample;    // One cycle from the pin
      else
         src_sample <= tone_sample;   // Two cycles from the phase
   end

endmodule

/* design/sine_quarter_rom.sv */
////////////////////////////////////////////////////////////
// Registered sine lookup
// Quarter-wave table of 65 entries
// Full period by mirroring the address and negating
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cic_settings.svh"

module sine_quarter_rom
   import cic_pkg::*;
(
   input  logic                        lr_clk,
   input  logic                        reset,
   input  logic [`CIC_ROM_ADDR_W-1:0]  phase_idx,   // Top bits of the phase
   output sample_t                     sine
);

   localparam int OFF_W = `CIC_ROM_ADDR_W - 2;   // Offset within a quadrant

   logic [1:0]                quadrant;
   logic [OFF_W-1:0]          offset;
   logic [OFF_W:0]            qaddr;             // 0 .. 64
   logic [`CIC_SAMPLE_W-2:0]  mag;               // Unsigned magnitude
   sample_t                   sine_next;

   assign quadrant = phase_idx[`CIC_ROM_ADDR_W-1 -: 2];
   assign offset   = phase_idx[OFF_W-1:0];

   // Quadrants 1 and 3 run the table backwards
   assign qaddr = quadrant[0] ? (OFF_W+1)'(2**OFF_W) - {1'b0, offset}
                              : {1'b0, offset};

   ////////////////////////////////////////////////////////////
   // First quadrant, round(peak * sin(2*pi*a/256))
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      case (qaddr)
         0:  mag = 15'd0;
         1:  mag = 15'd402;
         2:  mag = 15'd804;
         3:  mag = 15'd1205;
         4:  mag = 15'd1606;
         5:  mag = 15'd2005;
         6:  mag = 15'd2404;
         7:  mag = 15'd2801;
         8:  mag = 15'd3196;
         9:  mag = 15'd3590;
         10: mag = 15'd3981;
         11: mag = 15'd4370;
         12: mag = 15'd4756;
         13: mag = 15'd5139;
         14: mag = 15'd5519;
         15: mag = 15'd5896;
         16: mag = 15'd6270;
         17: mag = 15'd6639;
         18: mag = 15'd7005;
         19: mag = 15'd7366;
         20: mag = 15'd7723;
         21: mag = 15'd8075;
         22: mag = 15'd8423;
         23: mag = 15'd8765;
         24: mag = 15'd9102;
         25: mag = 15'd9433;
         26: mag = 15'd9759;
         27: mag = 15'd10079;
         28: mag = 15'd10393;
         29: mag = 15'd10701;
         30: mag = 15'd11002;
         31: mag = 15'd11297;
         32: mag = 15'd11585;   // 45 degrees
         33: mag = 15'd11865;
         34: mag = 15'd12139;
         35: mag = 15'd12405;
         36: mag = 15'd12664;
         37: mag = 15'd12915;
         38: mag = 15'd13159;
         39: mag = 15'd13394;
         40: mag = 15'd13622;
         41: mag = 15'd13841;
         42: mag = 15'd14052;
         43: mag = 15'd14255;
         44: mag = 15'd14449;
         45: mag = 15'd14634;
         46: mag = 15'd14810;
         47: mag = 15'd14977;
         48: mag = 15'd15136;
         49: mag = 15'd15285;
         50: mag = 15'd15425;
         51: mag = 15'd15556;
         52: mag = 15'd15678;
         53: mag = 15'd15790;
         54: mag = 15'd15892;
         55: mag = 15'd15985;
         56: mag = 15'd16068;
         57: mag = 15'd16142;
         58: mag = 15'd16206;
         59: mag = 15'd16260;
         60: mag = 15'd16304;
         61: mag = 15'd16339;
         62: mag = 15'd16363;
         63: mag = 15'd16378;
         default: mag = 15'(`CIC_SINE_PEAK);   // Index 64, the crest
      endcase
   end

   // Lower half of the period is negative
   assign sine_next = quadrant[1] ? -sample_t'({1'b0, mag}) : sample_t'({1'b0, mag});

   always_ff @(posedge lr_clk)
   begin
      if (reset)
         sine <= '0;
      else
         sine <= sine_next;
   end

endmodule

/* dv/cic_audio_tests.svh */
////////////////////////////////////////////////////////////
// Directed tests for the CIC audio decimator
// Reset state, output rate, ADC DC gain, step settling
// Tone lookup and tone through both filters
////////////////////////////////////////////////////////////
`ifndef CIC_AUDIO_TESTS_SVH
`define CIC_AUDIO_TESTS_SVH

// All outputs quiet
task automatic expect_idle();
   check_bit("sample_valid", sample_valid, 1'b0);
   check_sample("src_sample", src_sample, '0);
   check_sample("left_sample", left_sample, '0);
   check_sample("right_sample", right_sample, '0);
endtask

// Holds a DC value from the start of a window
// Each channel checked after its own count of outputs
task automatic apply_dc(input sample_t value, input int left_pulses, input int right_pulses);
   bit arrived;
   wait_valid(arrived);   // Align to a fresh window
   @(posedge lr_clk);
   #5;
   src_sel    = SRC_ADC;
   adc_sample = value;
   @(posedge lr_clk);     // Registered into src_sample here
   @(negedge lr_clk);
   #1;
   check_sample("src_sample", src_sample, value);
   for (int p = 1; p <= left_pulses || p <= right_pulses; p++)
   begin
      wait_valid(arrived);
      if (p == right_pulses)
         check_sample("right_sample", right_sample, value);
      if (p == left_pulses)
         check_sample("left_sample", left_sample, value);   // Gain normalised exactly
   end
endtask

////////////////////////////////////////////////////////////
// Reset and output timing
////////////////////////////////////////////////////////////
task automatic verify_reset();
   int errs_before;
   errs_before = errors;
   repeat (9)
   begin
      @(negedge lr_clk);
      #1;
      expect_idle();
   end
   @(posedge lr_clk);   // Tenth edge in reset
   #5;
   reset = 1'b0;
   @(posedge lr_clk);   // First edge after release
   @(negedge lr_clk);
   #1;
   expect_idle();
   report_test("reset_state", errs_before);
endtask

// One pulse per window, over 8 windows
task automatic output_rate();
   int errs_before;
   bit arrived;
   errs_before = errors;
   wait_valid(arrived);
   for (int w = 0; w < 8; w++)
   begin
      for (int c = 1; c < `CIC_DECIM_RATIO; c++)
      begin
         @(negedge lr_clk);
         #1;
         check_bit("sample_valid", sample_valid, 1'b0);
      end
      @(negedge lr_clk);
      #1;
      check_bit("sample_valid", sample_valid, 1'b1);   // Window boundary
   end
   report_test("output_rate", errs_before);
endtask

////////////////////////////////////////////////////////////
// ADC path
////////////////////////////////////////////////////////////
task automatic adc_dc_gain();
   int      errs_before;
   sample_t vals [4];
   errs_before = errors;
   vals[0] = sample_t'($urandom_range(32767, 1));
   vals[1] = -sample_t'($urandom_range(32767, 1));
   vals[2] = 16'sh7fff;   // Full scale positive
   vals[3] = 16'sh8000;   // Full scale negative
   for (int i = 0; i < 4; i++)
      apply_dc(vals[i], LEFT_ORDER + 2, RIGHT_ORDER + 2);
   report_test("adc_dc_gain", errs_before);
endtask

task automatic step_settling();
   int errs_before;
   errs_before = errors;
   apply_dc(sample_t'($urandom_range(32767, 1)), 6, 6);   // Step from negative full scale
   report_test("step_settling", errs_before);
endtask

////////////////////////////////////////////////////////////
// Tone generator
////////////////////////////////////////////////////////////
task automatic tone_lookup();
   int errs_before;
   int cycles;
   errs_before = errors;
   @(posedge lr_clk);
   #5;
   src_sel = SRC_TONE;
   for (int seg = 0; seg < 7; seg++)
   begin
      @(posedge lr_clk);
      #5;
      if (seg < 6)
      begin
         tone_shift = shift_t'($urandom_range(8, 0));
         cycles     = 256;
      end
      else
      begin
         tone_shift = 8;      // Fastest tone, about 979 cycles a period
         cycles     = 1024;
      end
      for (int i = 0; i < cycles; i++)
      begin
         @(negedge lr_clk);
         #1;
         check_sample("src_sample", src_sample,
                      sine_entry(ph_d2[`CIC_PHASE_W-1 -: `CIC_ROM_ADDR_W]));
      end
   end
   report_test("tone_lookup", errs_before);
endtask

// Tone through both decimators against the integer model
task automatic tone_filtering();
   int errs_before;
   bit arrived;
   errs_before = errors;
   @(posedge lr_clk);
   #5;
   src_sel    = SRC_TONE;
   tone_shift = shift_t'($urandom_range(8, 3));
   for (int p = 0; p < 12; p++)
   begin
      wait_valid(arrived);
      check_sample("left_sample", left_sample, exp_out[0]);
      check_sample("right_sample", right_sample, exp_out[1]);
   end
   report_test("tone_filtering", errs_before);
endtask

`endif

/* dv/cic_audio_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the CIC audio decimator
// Clock, reset, DUT instance and reference models
// Compare tasks, valid wait and test sequencing
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cic_settings.svh"

module cic_audio_tb
   import cic_pkg::*;
();

   localparam int  LEFT_ORDER    = 4;
   localparam int  RIGHT_ORDER   = 2;
   localparam int  VALID_TIMEOUT = 3 * `CIC_DECIM_RATIO;   // Cycles per valid wait
   localparam real PI            = 3.14159265358979;

   typedef logic [`CIC_SHIFT_W-1:0] shift_t;

   logic     lr_clk = 1'b0;
   logic     reset;
   src_sel_e src_sel;
   shift_t   tone_shift;
   sample_t  adc_sample;
   sample_t  src_sample;
   sample_t  left_sample;
   sample_t  right_sample;
   logic     sample_valid;

   int errors    = 0;
   int checks    = 0;
   int tests_run = 0;

   // Reference model state, index 0 left, 1 right
   logic    rst_seen = 1'b1;   // Reset level at the last edge
   shift_t  shift_seen;
   sample_t src_seen;          // src_sample before the last edge
   phase_t  ph;
   phase_t  ph_d1;
   phase_t  ph_d2;             // Phase two edges back
   longint  integ [2][4];
   longint  cap   [2];
   longint  dly   [2][4];
   sample_t exp_out [2];

   always #20 lr_clk = ~lr_clk;   // 40 ns period

   cic_audio_top cic_audio_i
   (
      .lr_clk       (lr_clk),
      .reset        (reset),
      .src_sel      (src_sel),
      .tone_shift   (tone_shift),
      .adc_sample   (adc_sample),
      .src_sample   (src_sample),
      .left_sample  (left_sample),
      .right_sample (right_sample),
      .sample_valid (sample_valid)
   );

   ////////////////////////////////////////////////////////////
   // Reference models
   ////////////////////////////////////////////////////////////

   // Ideal sine entry, rounded half away from zero
   function automatic sample_t sine_entry(input logic [`CIC_ROM_ADDR_W-1:0] idx);
      real amp;
      amp = `CIC_SINE_PEAK * $sin(2.0 * PI * idx / (2.0 ** `CIC_ROM_ADDR_W));
      if (amp >= 0.0)
         sine_entry = sample_t'($rtoi(amp + 0.5));
      else
         sine_entry = sample_t'(-$rtoi(0.5 - amp));
   endfunction

   // Comb at a tick, output from the capture of the tick before
   task automatic comb_step(input int ch);
      int     order;
      longint d [4];
      order = (ch == 0) ? LEFT_ORDER : RIGHT_ORDER;
      d[0] = cap[ch] - dly[ch][0];
      for (int k = 1; k < order; k++)
         d[k] = d[k-1] - dly[ch][k];
      exp_out[ch] = sample_t'(d[order-1] >>> (order * `CIC_DECIM_LOG2));   // DC gain
      dly[ch][0] = cap[ch];
      for (int k = 1; k < order; k++)
         dly[ch][k] = d[k-1];
      cap[ch] = integ[ch][order-1];
   endtask

   // One input-rate edge of the integrator chain
   task automatic integrate_step(input int ch);
      int order;
      order = (ch == 0) ? LEFT_ORDER : RIGHT_ORDER;
      for (int k = order - 1; k > 0; k--)
         integ[ch][k] = integ[ch][k] + integ[ch][k-1];   // Old lower stage
      integ[ch][0] = integ[ch][0] + longint'(src_seen);
   endtask

   // Models advance once per cycle, midway between edges
   always @(negedge lr_clk)
   begin
      if (rst_seen)
      begin
         ph    = '0;
         ph_d1 = '0;
         ph_d2 = '0;
         for (int c = 0; c < 2; c++)
         begin
            cap[c]     = 0;
            exp_out[c] = '0;
            for (int k = 0; k < 4; k++)
            begin
               integ[c][k] = 0;
               dly[c][k]   = 0;
            end
         end
      end
      else
      begin
         if (sample_valid)   // Tick was on the last edge
         begin
            comb_step(0);
            comb_step(1);
         end
         ph_d2 = ph_d1;
         ph_d1 = ph;
         ph    = ph + (phase_t'(`CIC_TONE_STEP) << shift_seen);
         integrate_step(0);
         integrate_step(1);
      end
      rst_seen   = reset;        // Levels the next edge will see
      shift_seen = tone_shift;
      src_seen   = src_sample;
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks and waits
   ////////////////////////////////////////////////////////////
   task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
      end
   endtask

   // Returns just after a negedge that shows sample_valid high
   task automatic wait_valid(output bit arrived);
      arrived = 1'b0;
      for (int n = 0; n < VALID_TIMEOUT && !arrived; n++)
      begin
         @(negedge lr_clk);
         #1;
         arrived = sample_valid;
      end
      if (!arrived)
      begin
         errors++;
         $display("sample_valid never arrived within %0d cycles at %0t", VALID_TIMEOUT, $time);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - errs_before);
   endtask

   `include "cic_audio_tests.svh"

   ////////////////////////////////////////////////////////////
   // Sequencing
   ////////////////////////////////////////////////////////////
   initial
   begin
      void'($urandom(54));   // Fixes the random sequence
      reset      = 1'b1;
      src_sel    = SRC_ADC;
      tone_shift = '0;
      adc_sample = '0;
      verify_reset();
      output_rate();
      adc_dc_gain();
      step_settling();
      tone_lookup();
      tone_filtering();
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
